/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = mem_subsys_tb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
logic/mem_pkg.sv
logic/cmd_queue.sv
logic/mem_stage.sv
logic/stall_mem.sv
logic/mem_subsys_top.sv
test/mem_subsys_tb.sv

/* logic/cmd_queue.sv */
// Command FIFO between the processor side and the memory stage.
// A push strobe writes one command; the oldest entry is always shown at head
// while empty is low. Pop and push may fall in the same cycle.
// A push while full is dropped.

`timescale 1ns/10ps

module cmd_queue (
   input  logic              clk,
   input  logic              rst,
   input  logic              cmd_push,
   input  mem_pkg::mem_cmd_t cmd,
   output logic              full,
   input  logic              pop,
   output mem_pkg::mem_cmd_t head,
   output logic              empty
);
   import mem_pkg::*;

   // Entry storage
   mem_cmd_t          entry [QUEUE_DEPTH];

   logic [QPTR_W-1:0] wr_ptr;
   logic [QPTR_W-1:0] rd_ptr;
   logic [QCNT_W-1:0] count;
   logic              push_ok;
   logic              pop_ok;

   // Wrap at the last entry so any depth works
   function automatic logic [QPTR_W-1:0] ptr_inc(input logic [QPTR_W-1:0] ptr);
      logic [QPTR_W-1:0] last;
      last = QPTR_W'(QUEUE_DEPTH - 1);
      return (ptr == last) ? '0 : ptr + 1'b1;
   endfunction

   // Drop illegal requests at the boundary
   assign push_ok = cmd_push && !full;
   assign pop_ok  = pop && !empty;

   assign full  = (count == QCNT_W'(QUEUE_DEPTH));
   assign empty = (count == '0);
   assign head  = entry[rd_ptr];

   ////////////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push_ok)
            wr_ptr <= ptr_inc(wr_ptr);
         if (pop_ok)
            rd_ptr <= ptr_inc(rd_ptr);
         // Simultaneous push and pop keeps the count
         case ({push_ok, pop_ok})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Payload write
   always_ff @(posedge clk) begin
      if (push_ok)
         entry[wr_ptr] <= cmd;
   end

   // Processor side must honor full
   a_no_push_full: assert property (@(posedge clk) disable iff (rst)
      full |-> !cmd_push);

   // Memory stage only pops a valid head
   a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
      empty |-> !pop);

endmodule

/* logic/mem_pkg.sv */
// Shared types and constants for the data-memory subsystem.
// Holds the address and data widths, the command, request, response and
// result structs, the queue sizing and the stall LFSR settings.
// Modules import this package inside their bodies.

package mem_pkg;

   // Byte address and data word widths
   localparam int ADDR_W = 16;
   localparam int WORD_W = 32;

   // One byte per address across the whole address space
   localparam int MEM_BYTES = 2 ** ADDR_W;

   // Command queue sizing
   localparam int QUEUE_DEPTH = 4;
   localparam int QPTR_W      = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W      = $clog2(QUEUE_DEPTH + 1);

   // Stall pattern generator
   // Shifts right with feedback into bit 31 from taps 31, 21, 1 and 0
   localparam int                LFSR_W    = 32;
   localparam logic [LFSR_W-1:0] LFSR_SEED = 32'h5262_9E0A;

   typedef logic [ADDR_W-1:0] addr_t;
   typedef logic [WORD_W-1:0] word_t;

   // Command as issued by the processor side
   typedef struct packed {
      logic  wr;
      addr_t addr;
      word_t wdata;
   } mem_cmd_t;

   // Request on the memory port, held until ready
   typedef struct packed {
      logic  enable;
      logic  wr;
      addr_t addr;
      word_t wdata;
   } mem_req_t;

   // Memory response, valid in the ready cycle
   typedef struct packed {
      logic  ready;
      logic  err;
      word_t rdata;
   } mem_rsp_t;

   // Finished access handed back to the processor side
   typedef struct packed {
      logic  err;
      word_t rdata;
   } mem_result_t;

   // Memory stage FSM
   typedef enum logic {
      IDLE,
      ACCESS
   } stage_state_t;

endpackage

/* logic/mem_stage.sv */
// Memory stage between the command queue and the stalling memory.
// Pops one command, presents it on the memory port and keeps it there
// unchanged until the memory signals ready. The ready cycle is the access;
// its error flag and load data are registered and flagged by a done pulse.
// The next command can be popped in the cycle that done is high.

`timescale 1ns/10ps

module mem_stage (
   input  logic                 clk,
   input  logic                 rst,
   input  mem_pkg::mem_cmd_t    head,
   input  logic                 empty,
   output logic                 pop,
   output mem_pkg::mem_req_t    req,
   input  mem_pkg::mem_rsp_t    rsp,
   output logic                 done,
   output mem_pkg::mem_result_t result,
   output logic                 busy
);
   import mem_pkg::*;

   stage_state_t state;
   stage_state_t state_next;

   // Request register, held across stall cycles
   mem_cmd_t     cmd_q;

   // High in the one cycle where the memory takes the access
   logic         access_done;

   ////////////////////////////////////////////////////////////////////////////
   // FSM
   ////////////////////////////////////////////////////////////////////////////

   assign access_done = (state == ACCESS) && rsp.ready;

   // Take a new command whenever idle and one is waiting
   assign pop = (state == IDLE) && !empty;

   always_comb begin
      state_next = state;
      case (state)
         IDLE: begin
            if (!empty)
               state_next = ACCESS;
         end
         ACCESS: begin
            // Stay here through every stall cycle
            if (rsp.ready)
               state_next = IDLE;
         end
         default: state_next = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= IDLE;
         done  <= 1'b0;
      end else begin
         state <= state_next;
         done  <= access_done;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      // Latch the head at the pop edge
      if (pop)
         cmd_q <= head;
      // Capture the response on the access cycle
      if (access_done)
         result <= '{err: rsp.err, rdata: rsp.rdata};
   end

   // Enable comes from the state so it is clean right after reset
   assign req = '{
      enable: (state == ACCESS),
      wr:     cmd_q.wr,
      addr:   cmd_q.addr,
      wdata:  cmd_q.wdata
   };

   assign busy = (state == ACCESS);

   // A stalled request stays put until the memory takes it
   a_req_stable: assert property (@(posedge clk) disable iff (rst)
      (req.enable && !rsp.ready) |=> $stable(req));

endmodule

/* logic/mem_subsys_top.sv */
// Top of the data-memory subsystem.
// The processor side pushes commands into a short queue and watches full.
// A memory stage drains the queue one command at a time into the stalling
// memory and reports each finished access with a done pulse.
// Results leave in push order, one per command.

`timescale 1ns/10ps

module mem_subsys_top (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cmd_push,
   input  mem_pkg::mem_cmd_t    cmd,
   output logic                 full,
   output logic                 done,
   output mem_pkg::mem_result_t result,
   output logic                 busy
);
   import mem_pkg::*;

   // Queue to stage
   mem_cmd_t head;
   logic     empty;
   logic     pop;

   // Stage to memory
   mem_req_t req;
   mem_rsp_t rsp;

   ////////////////////////////////////////////////////////////////////////////
   // Command queue
   ////////////////////////////////////////////////////////////////////////////

   cmd_queue u_cmd_queue (
      .clk      (clk),
      .rst      (rst),
      .cmd_push (cmd_push),
      .cmd      (cmd),
      .full     (full),
      .pop      (pop),
      .head     (head),
      .empty    (empty)
   );

   // Memory stage
   mem_stage u_mem_stage (
      .clk    (clk),
      .rst    (rst),
      .head   (head),
      .empty  (empty),
      .pop    (pop),
      .req    (req),
      .rsp    (rsp),
      .done   (done),
      .result (result),
      .busy   (busy)
   );

   // Stalling memory
   stall_mem u_stall_mem (
      .clk (clk),
      .rst (rst),
      .req (req),
      .rsp (rsp)
   );

endmodule

/* logic/stall_mem.sv */
// Byte-addressed 64 KB data memory that stalls on a pseudo-random pattern.
// Serves 32-bit little-endian words; an access with either low address
// bit set is misaligned and reports err in its ready cycle.
// Loads return data combinationally in the ready cycle. Stores write at the
// edge that ends the ready cycle unless err is set.

`timescale 1ns/10ps

module stall_mem (
   input  logic              clk,
   input  logic              rst,
   input  mem_pkg::mem_req_t req,
   output mem_pkg::mem_rsp_t rsp
);
   import mem_pkg::*;

   // Byte array with contents undefined until written
   logic [7:0]        mem [MEM_BYTES];

   // Stall pattern
   logic [LFSR_W-1:0] lfsr;
   logic              lfsr_fb;

   // Byte addresses of the word that wrap at the top of memory
   addr_t             addr_b0;
   addr_t             addr_b1;
   addr_t             addr_b2;
   addr_t             addr_b3;

   logic              ready;
   logic              err;
   logic              misaligned;
   logic              rd_ok;
   logic              wr_ok;
   word_t             read_word;
   word_t             rdata;

   ////////////////////////////////////////////////////////////////////////////
   // Stall generator
   ////////////////////////////////////////////////////////////////////////////

   // Taps 31, 21, 1 and 0 feed the new top bit
   assign lfsr_fb = lfsr[0] ^ lfsr[1] ^ lfsr[21] ^ lfsr[31];

   always_ff @(posedge clk) begin
      if (rst)
         lfsr <= LFSR_SEED;
      else
         lfsr <= {lfsr_fb, lfsr[LFSR_W-1:1]};
   end

   // Only an enabled request can see ready
   assign ready = req.enable && lfsr[0];

   ////////////////////////////////////////////////////////////////////////////
   // Access decode
   ////////////////////////////////////////////////////////////////////////////

   assign misaligned = |req.addr[1:0];
   assign err        = ready && misaligned;

   // Good load or good store in the ready cycle
   assign rd_ok = ready && !req.wr && !err;
   assign wr_ok = ready && req.wr && !err;

   assign addr_b0 = req.addr;
   assign addr_b1 = req.addr + addr_t'(1);
   assign addr_b2 = req.addr + addr_t'(2);
   assign addr_b3 = req.addr + addr_t'(3);

   // Lowest address holds the least significant byte
   assign read_word = {mem[addr_b3], mem[addr_b2], mem[addr_b1], mem[addr_b0]};

   // Zero unless a clean load is taken this cycle
   assign rdata = rd_ok ? read_word : '0;

   assign rsp = '{ready: ready, err: err, rdata: rdata};

   ////////////////////////////////////////////////////////////////////////////
   // Store path
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (wr_ok) begin
         mem[addr_b0] <= req.wdata[7:0];
         mem[addr_b1] <= req.wdata[15:8];
         mem[addr_b2] <= req.wdata[23:16];
         mem[addr_b3] <= req.wdata[31:24];
      end
   end

   // An all-zero LFSR would stall every access forever
   a_lfsr_live: assert property (@(posedge clk) disable iff (rst)
      lfsr != '0);

endmodule

/* test/mem_subsys_tb.sv */
// Testbench for the data-memory subsystem.
// Builds a table of loads and stores, pushes it through the command queue
// while honoring full, and checks every done result in push order against
// a byte-array reference model. A watchdog bounds the run.

`timescale 1ns/10ps

module mem_subsys_tb;
   import mem_pkg::*;

   localparam int RESET_CYCLES   = 16;
   localparam int NUM_CMDS       = 20;
   localparam int TIMEOUT_CYCLES = NUM_CMDS * 200 + RESET_CYCLES;

   logic        clk;
   logic        rst;
   logic        cmd_push;
   mem_cmd_t    cmd;
   logic        full;
   logic        done;
   mem_result_t result;
   logic        busy;

   // Command table with the expected error flag per entry
   logic        tbl_wr    [NUM_CMDS];
   addr_t       tbl_addr  [NUM_CMDS];
   word_t       tbl_wdata [NUM_CMDS];
   logic        tbl_err   [NUM_CMDS];
   int          n_cmds;

   // Reference memory of little-endian bytes
   logic [7:0]  ref_mem [MEM_BYTES];

   logic [31:0] lcg_state;
   int          errors;
   int          pass_cnt;
   int          fail_cnt;
   logic        saw_full;

   mem_subsys_top DUT (
      .clk      (clk),
      .rst      (rst),
      .cmd_push (cmd_push),
      .cmd      (cmd),
      .full     (full),
      .done     (done),
      .result   (result),
      .busy     (busy)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // LCG step for store data
   function automatic word_t next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   task automatic add_cmd(input logic wr, input addr_t addr, input word_t wdata,
                          input logic err);
      tbl_wr[n_cmds]    = wr;
      tbl_addr[n_cmds]  = addr;
      tbl_wdata[n_cmds] = wdata;
      tbl_err[n_cmds]   = err;
      n_cmds            = n_cmds + 1;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      rst       = 1'b1;
      cmd_push  = 1'b0;
      cmd       = '0;
      lcg_state = 32'd98351;
      n_cmds    = 0;
      errors    = 0;
      saw_full  = 1'b0;
      // Store then load back, then a burst long enough to fill the queue
      add_cmd(1'b1, 16'h0100, next_rand(), 1'b0);
      add_cmd(1'b0, 16'h0100, '0, 1'b0);
      add_cmd(1'b1, 16'h0104, next_rand(), 1'b0);
      add_cmd(1'b1, 16'h0108, next_rand(), 1'b0);
      add_cmd(1'b1, 16'h010C, next_rand(), 1'b0);
      add_cmd(1'b1, 16'h0110, next_rand(), 1'b0);
      // Known bytes for the byte order check
      add_cmd(1'b1, 16'h0200, 32'h4433_2211, 1'b0);
      add_cmd(1'b1, 16'h0204, 32'h8877_6655, 1'b0);
      add_cmd(1'b0, 16'h0104, '0, 1'b0);
      add_cmd(1'b0, 16'h0108, '0, 1'b0);
      add_cmd(1'b0, 16'h010C, '0, 1'b0);
      add_cmd(1'b0, 16'h0110, '0, 1'b0);
      // Misaligned store across the words at 0x100 and 0x104 and a misaligned load
      add_cmd(1'b1, 16'h0101, next_rand(), 1'b1);
      add_cmd(1'b0, 16'h0102, '0, 1'b1);
      add_cmd(1'b0, 16'h0100, '0, 1'b0);
      add_cmd(1'b0, 16'h0104, '0, 1'b0);
      add_cmd(1'b0, 16'h0200, '0, 1'b0);
      add_cmd(1'b0, 16'h0204, '0, 1'b0);
      add_cmd(1'b1, 16'h0203, next_rand(), 1'b1);
      add_cmd(1'b0, 16'h0200, '0, 1'b0);

      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      // Control outputs idle after reset
      assert (!done && !busy && !full) else begin
         $display("Error at %0t ns: done/busy/full = %b%b%b, expected 000",
                  $time, done, busy, full);
         errors = errors + 1;
      end

      // Back to back pushes that hold while the queue is full
      for (int i = 0; i < NUM_CMDS; i++) begin
         while (full) begin
            saw_full = 1'b1;
            cmd_push = 1'b0;
            @(negedge clk);
         end
         cmd_push = 1'b1;
         cmd      = '{wr: tbl_wr[i], addr: tbl_addr[i], wdata: tbl_wdata[i]};
         @(negedge clk);
      end
      cmd_push = 1'b0;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Result checker
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      word_t exp_rdata;
      addr_t a;
      addr_t ba;
      logic  ok;
      logic  busy_prev;
      pass_cnt = 0;
      fail_cnt = 0;
      for (int i = 0; i < NUM_CMDS; i++) begin
         busy_prev = 1'b0;
         @(negedge clk);
         while (done !== 1'b1) begin
            busy_prev = busy;
            @(negedge clk);
         end
         a  = tbl_addr[i];
         ok = 1'b1;
         // The access cycle just before done is spent in ACCESS
         assert (busy_prev === 1'b1) else begin
            $display("Error at %0t ns: busy = %b in the cycle before done, expected 1",
                     $time, busy_prev);
            ok = 1'b0;
         end
         // Stores and errors return zero data
         if (tbl_err[i] || tbl_wr[i])
            exp_rdata = '0;
         else
            exp_rdata = {ref_mem[a + addr_t'(3)], ref_mem[a + addr_t'(2)],
                         ref_mem[a + addr_t'(1)], ref_mem[a]};
         assert (result.err == tbl_err[i]) else begin
            $display("Error at %0t ns: result.err = %b, expected %b",
                     $time, result.err, tbl_err[i]);
            ok = 1'b0;
         end
         assert (result.rdata === exp_rdata) else begin
            $display("Error at %0t ns: result.rdata = %h, expected %h",
                     $time, result.rdata, exp_rdata);
            ok = 1'b0;
         end
         // Model follows push order and skips misaligned stores
         if (tbl_wr[i] && !tbl_err[i]) begin
            ref_mem[a]              = tbl_wdata[i][7:0];
            ref_mem[a + addr_t'(1)] = tbl_wdata[i][15:8];
            ref_mem[a + addr_t'(2)] = tbl_wdata[i][23:16];
            ref_mem[a + addr_t'(3)] = tbl_wdata[i][31:24];
            // Stored bytes sit little-endian in the memory array
            for (int b = 0; b < 4; b++) begin
               ba = a + addr_t'(b);
               assert (DUT.u_stall_mem.mem[ba] === ref_mem[ba]) else begin
                  $display("Error at %0t ns: u_stall_mem.mem[%h] = %h, expected %h",
                           $time, ba, DUT.u_stall_mem.mem[ba], ref_mem[ba]);
                  ok = 1'b0;
               end
            end
         end
         if (ok)
            pass_cnt = pass_cnt + 1;
         else
            fail_cnt = fail_cnt + 1;
         $display("cmd %0d %s addr %h: %s", i, tbl_wr[i] ? "store" : "load ",
                  a, ok ? "ok" : "mismatch");
      end

      // No extra results once the table is drained
      repeat (20) begin
         @(negedge clk);
         assert (!done) else begin
            $display("Extra done pulse at %0t ns with no command left", $time);
            errors = errors + 1;
         end
      end
      assert (saw_full) else begin
         $display("The full level never rose during the burst");
         errors = errors + 1;
      end

      $display("%0d commands, %0d passed, %0d failed, %0d other errors",
               NUM_CMDS, pass_cnt, fail_cnt, errors);
      if (fail_cnt == 0 && errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

   // Watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Run timed out after %0d cycles with %0d of %0d results seen",
               TIMEOUT_CYCLES, pass_cnt + fail_cnt, NUM_CMDS);
      $display("Test FAILED");
      $finish;
   end

endmodule
